//--- hdl/mips_pkg.sv
package mips_pkg;

    // ==============================
    // widths
    // ==============================

    // data and address width, one word
    localparam int xlen = 32;

    // register index width
    localparam int reg_addr_w = 5;

    // link register written by jal
    localparam logic [reg_addr_w-1:0] ra_index = 5'd31;

    // ==============================
    // instruction encodings
    // ==============================

    // primary opcode, ir[31:26]
    typedef enum logic [5:0] {
        r_type = 6'h00,
        j      = 6'h02,
        jal    = 6'h03,
        beq    = 6'h04,
        addi   = 6'h08,
        lw     = 6'h23,
        sw     = 6'h2B
    } opcode_e;

    // function field of r-type, ir[5:0]
    typedef enum logic [5:0] {
        f_jr  = 6'h08,
        f_add = 6'h20,
        f_sub = 6'h22,
        f_and = 6'h24,
        f_or  = 6'h25,
        f_slt = 6'h2A
    } funct_e;

    // ==============================
    // alu operations
    // ==============================

    // resolved by the decoder, one step
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

endpackage

//--- hdl/mips_decoder.sv
module mips_decoder (
    input  logic [5:0]        opcode,
    input  logic [5:0]        funct,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch,
    output logic              jump,
    output logic              is_jal,
    output logic              is_jr,
    output mips_pkg::alu_op_e alu_op
);

    mips_pkg::opcode_e op;
    mips_pkg::funct_e  fn;

    assign op = mips_pkg::opcode_e'(opcode);
    assign fn = mips_pkg::funct_e'(funct);

    always_comb begin
        // unknown encodings fall through as a no-op
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        is_jal     = 1'b0;
        is_jr      = 1'b0;
        alu_op     = mips_pkg::alu_add;
        case (op)
            mips_pkg::r_type: begin
                reg_dst = 1'b1;
                // funct picks the alu op directly
                case (fn)
                    mips_pkg::f_add: reg_write = 1'b1;
                    mips_pkg::f_sub: begin
                        reg_write = 1'b1;
                        alu_op    = mips_pkg::alu_sub;
                    end
                    mips_pkg::f_and: begin
                        reg_write = 1'b1;
                        alu_op    = mips_pkg::alu_and;
                    end
                    mips_pkg::f_or: begin
                        reg_write = 1'b1;
                        alu_op    = mips_pkg::alu_or;
                    end
                    mips_pkg::f_slt: begin
                        reg_write = 1'b1;
                        alu_op    = mips_pkg::alu_slt;
                    end
                    mips_pkg::f_jr: is_jr = 1'b1;
                    default: reg_dst = 1'b1;
                endcase
            end
            mips_pkg::addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::lw: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            mips_pkg::sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::beq: begin
                branch = 1'b1;
                alu_op = mips_pkg::alu_sub;
            end
            mips_pkg::j: jump = 1'b1;
            mips_pkg::jal: begin
                jump      = 1'b1;
                is_jal    = 1'b1;
                reg_write = 1'b1;
            end
            default: alu_op = mips_pkg::alu_add;
        endcase
    end

endmodule

//--- hdl/mips_alu.sv
module mips_alu (
    input  logic [mips_pkg::xlen-1:0] a,
    input  logic [mips_pkg::xlen-1:0] b,
    input  mips_pkg::alu_op_e         op,
    output logic [mips_pkg::xlen-1:0] result,
    output logic                      zero
);

    always_comb begin
        case (op)
            mips_pkg::alu_add: begin
                result = a + b;
            end
            mips_pkg::alu_sub: begin
                result = a - b;
            end
            mips_pkg::alu_and: begin
                result = a & b;
            end
            mips_pkg::alu_or: begin
                result = a | b;
            end
            // signed compare, one in bit 0
            mips_pkg::alu_slt: begin
                result = {{(mips_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // flag on any operation, beq uses it after sub
    assign zero = (result == '0);

endmodule

//--- hdl/mips_regfile.sv
module mips_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [mips_pkg::reg_addr_w-1:0] raddr1,
    input  logic [mips_pkg::reg_addr_w-1:0] raddr2,
    input  logic [mips_pkg::reg_addr_w-1:0] waddr,
    input  logic [mips_pkg::xlen-1:0]       wdata,
    output logic [mips_pkg::xlen-1:0]       rdata1,
    output logic [mips_pkg::xlen-1:0]       rdata2
);

    localparam int depth = 2 ** mips_pkg::reg_addr_w;

    logic [mips_pkg::xlen-1:0] regs [0:depth-1];

    // ==============================
    // read ports
    // ==============================

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // ==============================
    // write port
    // ==============================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- hdl/mips_core.sv
module mips_core #(
    parameter int DMEM_ADDR_W = 7
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mips_pkg::xlen-1:0]       ir,
    input  logic [mips_pkg::xlen-1:0]       rdata,
    output logic [mips_pkg::xlen-1:0]       ir_addr,
    output logic                            cen,
    output logic                            wen,
    output logic                            oen,
    output logic [DMEM_ADDR_W-1:0]          a,
    output logic [mips_pkg::xlen-1:0]       wdata,
    output logic                            rf_we,
    output logic [mips_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [mips_pkg::xlen-1:0]       rf_wdata
);

    logic [mips_pkg::xlen-1:0]       pc;
    logic [mips_pkg::xlen-1:0]       pc_plus_4;
    logic [mips_pkg::xlen-1:0]       pc_next;
    logic [mips_pkg::xlen-1:0]       imm_sext;
    logic [mips_pkg::xlen-1:0]       branch_target;
    logic [mips_pkg::xlen-1:0]       jump_target;
    logic [mips_pkg::reg_addr_w-1:0] rs;
    logic [mips_pkg::reg_addr_w-1:0] rt;
    logic [mips_pkg::reg_addr_w-1:0] rd;
    logic [mips_pkg::xlen-1:0]       rs_data;
    logic [mips_pkg::xlen-1:0]       rt_data;
    logic [mips_pkg::xlen-1:0]       alu_b;
    logic [mips_pkg::xlen-1:0]       alu_result;
    logic                            alu_zero;
    logic                            reg_dst;
    logic                            alu_src;
    logic                            mem_to_reg;
    logic                            reg_write;
    logic                            mem_read;
    logic                            mem_write;
    logic                            branch;
    logic                            jump;
    logic                            is_jal;
    logic                            is_jr;
    mips_pkg::alu_op_e               alu_op;

    assign rs       = ir[25:21];
    assign rt       = ir[20:16];
    assign rd       = ir[15:11];
    assign imm_sext = {{16{ir[15]}}, ir[15:0]};

    mips_decoder u_decoder (
        .opcode     (ir[31:26]),
        .funct      (ir[5:0]),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .is_jal     (is_jal),
        .is_jr      (is_jr),
        .alu_op     (alu_op)
    );

    mips_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .raddr1 (rs),
        .raddr2 (rt),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rs_data),
        .rdata2 (rt_data)
    );

    assign alu_b = alu_src ? imm_sext : rt_data;

    mips_alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ==============================
    // next pc
    // ==============================

    assign pc_plus_4     = pc + 32'd4;
    assign branch_target = pc_plus_4 + {imm_sext[mips_pkg::xlen-3:0], 2'b00};
    // region of pc+4 joined with the word target
    assign jump_target   = {pc_plus_4[31:28], ir[25:0], 2'b00};

    always_comb begin
        if (is_jr) begin
            pc_next = rs_data;
        end else if (jump) begin
            pc_next = jump_target;
        end else if (branch && alu_zero) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign ir_addr = pc;

    // ==============================
    // writeback and sram strobes
    // ==============================

    // a write to r0 never shows on the trace
    assign rf_we    = reg_write && !rst_n && (rf_waddr != '0);
    assign rf_waddr = is_jal ? mips_pkg::ra_index : (reg_dst ? rd : rt);
    assign rf_wdata = is_jal ? pc_plus_4 : (mem_to_reg ? rdata : alu_result);

    // strobes are active low, held off in reset
    assign cen   = !((mem_read || mem_write) && !rst_n);
    assign wen   = !(mem_write && !rst_n);
    assign oen   = 1'b0;
    assign a     = alu_result[DMEM_ADDR_W+1:2];
    assign wdata = rt_data;

endmodule

//--- hdl/mips_dmem.sv
module mips_dmem #(
    parameter int DMEM_ADDR_W = 7
) (
    input  logic                      clk,
    input  logic                      cen,
    input  logic                      wen,
    input  logic                      oen,
    input  logic [DMEM_ADDR_W-1:0]    a,
    input  logic [mips_pkg::xlen-1:0] wdata,
    output logic [mips_pkg::xlen-1:0] rdata
);

    localparam int depth = 2 ** DMEM_ADDR_W;

    // word array, behaves like an sram macro
    logic [mips_pkg::xlen-1:0] mem [0:depth-1];

    logic write_en;
    logic read_en;

    // ==============================
    // strobe decode
    // ==============================

    // all strobes active low
    assign write_en = !cen && !wen;
    assign read_en  = !cen && wen && !oen;

    // ==============================
    // array access
    // ==============================

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[a] <= wdata;
        end
    end

    // asynchronous read, zero when deselected
    assign rdata = read_en ? mem[a] : '0;

endmodule

//--- hdl/mips_system.sv
module mips_system #(
    parameter int DMEM_ADDR_W = 7
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mips_pkg::xlen-1:0]       ir,
    output logic [mips_pkg::xlen-1:0]       ir_addr,
    output logic                            rf_we,
    output logic [mips_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [mips_pkg::xlen-1:0]       rf_wdata
);

    // sram strobe wires
    logic                      cen;
    logic                      wen;
    logic                      oen;
    logic [DMEM_ADDR_W-1:0]    a;
    logic [mips_pkg::xlen-1:0] wdata;
    logic [mips_pkg::xlen-1:0] rdata;

    mips_core #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .ir       (ir),
        .rdata    (rdata),
        .ir_addr  (ir_addr),
        .cen      (cen),
        .wen      (wen),
        .oen      (oen),
        .a        (a),
        .wdata    (wdata),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    mips_dmem #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_dmem (
        .clk   (clk),
        .cen   (cen),
        .wen   (wen),
        .oen   (oen),
        .a     (a),
        .wdata (wdata),
        .rdata (rdata)
    );

endmodule

//--- dv/mips_system_chk.sv
module mips_system_chk (
    input logic                            clk,
    input logic                            rst_n,
    input logic [mips_pkg::xlen-1:0]       ir_addr,
    input logic                            rf_we,
    input logic [mips_pkg::reg_addr_w-1:0] rf_waddr
);

    timeunit 1ns;
    timeprecision 100ps;

    // ==============================
    // fetch
    // ==============================

    assert property (@(posedge clk) disable iff (rst_n) ir_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // first cycle out of reset fetches from zero
    assert property (@(posedge clk) $fell(rst_n) |-> ir_addr == '0)
        else $error("fetch did not start at address 0");

    // ==============================
    // writeback
    // ==============================

    assert property (@(posedge clk) rst_n |-> !rf_we)
        else $error("register write during reset");

    assert property (@(posedge clk) disable iff (rst_n) rf_we |-> rf_waddr != '0)
        else $error("register write to r0");

endmodule

bind mips_system mips_system_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .ir_addr  (ir_addr),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr)
);

//--- dv/mips_system_tb.sv
module mips_system_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int dmem_addr_w = 7;
    // six tests of about 15 cycles each, with a wide margin
    localparam int max_cycles = 1000;
    // add r0, r0, r0
    localparam logic [31:0] nop = 32'h0000_0020;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [mips_pkg::xlen-1:0]       ir;
    logic [mips_pkg::xlen-1:0]       ir_addr;
    logic                            rf_we;
    logic [mips_pkg::reg_addr_w-1:0] rf_waddr;
    logic [mips_pkg::xlen-1:0]       rf_wdata;

    logic [31:0] imem [0:63];
    logic [31:0] m_regs [0:31];
    logic [31:0] m_dmem [0:2**dmem_addr_w-1];
    logic [31:0] m_pc;
    int          prog_len;
    int          errors = 0;
    int          cycles = 0;

    always #20 clk = ~clk;

    // instruction memory answers in the same cycle
    assign ir = imem[ir_addr[7:2]];

    mips_system #(
        .DMEM_ADDR_W (dmem_addr_w)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ir       (ir),
        .ir_addr  (ir_addr),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ==============================
    // compare tasks
    // ==============================

    task automatic check_word(logic [mips_pkg::xlen-1:0] got,
                              logic [mips_pkg::xlen-1:0] exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(logic [mips_pkg::reg_addr_w-1:0] got,
                             logic [mips_pkg::reg_addr_w-1:0] exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ==============================
    // encoders and program loading
    // ==============================

    function automatic logic [31:0] enc_r(mips_pkg::funct_e fn, logic [4:0] rd,
                                          logic [4:0] rs, logic [4:0] rt);
        return {mips_pkg::r_type, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(mips_pkg::opcode_e op, logic [4:0] rt,
                                          logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(mips_pkg::opcode_e op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic put(logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // core held in reset while the next program is loaded
    task automatic start_reset();
        rst_n = 1'b1;
        prog_len = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop;
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc = '0;
    endtask

    task automatic end_reset();
        repeat (5) begin
            @(negedge clk);
            check_flag(rf_we, 1'b0, "rf_we in reset");
            @(posedge clk);
            #2;
        end
        rst_n = 1'b0;
    endtask

    // ==============================
    // isa model, one instruction per call
    // ==============================

    task automatic step();
        logic [31:0]       instr;
        logic [31:0]       va;
        logic [31:0]       vb;
        logic [31:0]       sext;
        logic [31:0]       addr;
        logic [31:0]       pc4;
        logic [31:0]       npc;
        logic              e_we;
        logic [4:0]        e_wa;
        logic [31:0]       e_wd;
        mips_pkg::opcode_e op;
        mips_pkg::funct_e  fn;
        instr = imem[m_pc[7:2]];
        op    = mips_pkg::opcode_e'(instr[31:26]);
        fn    = mips_pkg::funct_e'(instr[5:0]);
        va    = m_regs[instr[25:21]];
        vb    = m_regs[instr[20:16]];
        sext  = {{16{instr[15]}}, instr[15:0]};
        addr  = va + sext;
        pc4   = m_pc + 32'd4;
        npc   = pc4;
        e_we  = 1'b0;
        e_wa  = instr[20:16];
        e_wd  = addr;
        case (op)
            mips_pkg::r_type: begin
                e_we = 1'b1;
                e_wa = instr[15:11];
                case (fn)
                    mips_pkg::f_add: e_wd = va + vb;
                    mips_pkg::f_sub: e_wd = va - vb;
                    mips_pkg::f_and: e_wd = va & vb;
                    mips_pkg::f_or:  e_wd = va | vb;
                    mips_pkg::f_slt: e_wd = {31'd0, $signed(va) < $signed(vb)};
                    mips_pkg::f_jr: begin
                        e_we = 1'b0;
                        npc  = va;
                    end
                    default: e_we = 1'b0;
                endcase
            end
            mips_pkg::addi: e_we = 1'b1;
            mips_pkg::lw: begin
                e_we = 1'b1;
                e_wd = m_dmem[addr[dmem_addr_w+1:2]];
            end
            mips_pkg::beq: begin
                if (va == vb) begin
                    npc = pc4 + (sext << 2);
                end
            end
            mips_pkg::j: npc = {pc4[31:28], instr[25:0], 2'b00};
            mips_pkg::jal: begin
                npc  = {pc4[31:28], instr[25:0], 2'b00};
                e_we = 1'b1;
                e_wa = mips_pkg::ra_index;
                e_wd = pc4;
            end
            default: e_we = 1'b0;
        endcase
        // r0 is never written, so no write shows on the port
        if (e_wa == 5'd0) begin
            e_we = 1'b0;
        end
        @(negedge clk);
        check_word(ir_addr, m_pc, "ir_addr");
        check_flag(rf_we, e_we, "rf_we");
        if (e_we) begin
            check_reg(rf_waddr, e_wa, "rf_waddr");
            check_word(rf_wdata, e_wd, "rf_wdata");
        end
        if (op == mips_pkg::sw) begin
            m_dmem[addr[dmem_addr_w+1:2]] = vb;
        end
        if (e_we) begin
            m_regs[e_wa] = e_wd;
        end
        m_pc = npc;
        @(posedge clk);
        #2;
    endtask

    task automatic run(int n);
        repeat (n) step();
    endtask

    // ==============================
    // directed tests
    // ==============================

    task automatic test_reset();
        start_reset();
        end_reset();
        run(4);
    endtask

    task automatic test_alu();
        logic [15:0] i1;
        logic [15:0] i2;
        i1 = 16'($urandom());
        i2 = 16'($urandom());
        start_reset();
        put(enc_i(mips_pkg::addi, 5'd1, 5'd0, i1));
        put(enc_i(mips_pkg::addi, 5'd2, 5'd0, i2));
        put(enc_i(mips_pkg::addi, 5'd3, 5'd0, 16'hfffb));
        put(enc_r(mips_pkg::f_add, 5'd4, 5'd1, 5'd2));
        put(enc_r(mips_pkg::f_sub, 5'd5, 5'd1, 5'd2));
        put(enc_r(mips_pkg::f_and, 5'd6, 5'd1, 5'd2));
        put(enc_r(mips_pkg::f_or, 5'd7, 5'd1, 5'd2));
        put(enc_r(mips_pkg::f_slt, 5'd8, 5'd3, 5'd1));
        put(enc_r(mips_pkg::f_slt, 5'd9, 5'd1, 5'd3));
        end_reset();
        run(9);
    endtask

    task automatic test_mem();
        start_reset();
        put(enc_i(mips_pkg::addi, 5'd1, 5'd0, 16'($urandom())));
        put(enc_i(mips_pkg::addi, 5'd2, 5'd0, 16'($urandom())));
        put(enc_i(mips_pkg::addi, 5'd10, 5'd0, 16'd16));
        put(enc_i(mips_pkg::addi, 5'd11, 5'd0, 16'd8));
        put(enc_i(mips_pkg::sw, 5'd1, 5'd10, 16'd0));
        put(enc_i(mips_pkg::sw, 5'd2, 5'd10, 16'd4));
        put(enc_i(mips_pkg::sw, 5'd2, 5'd10, 16'hfff8));
        put(enc_i(mips_pkg::lw, 5'd3, 5'd10, 16'd4));
        put(enc_i(mips_pkg::lw, 5'd4, 5'd10, 16'd0));
        put(enc_i(mips_pkg::lw, 5'd5, 5'd10, 16'hfff8));
        put(enc_i(mips_pkg::lw, 5'd6, 5'd11, 16'd8));
        end_reset();
        run(11);
    endtask

    task automatic test_branch();
        start_reset();
        put(enc_i(mips_pkg::addi, 5'd1, 5'd0, 16'd7));
        put(enc_i(mips_pkg::addi, 5'd2, 5'd0, 16'd7));
        put(enc_i(mips_pkg::beq, 5'd2, 5'd1, 16'd4));
        put(enc_i(mips_pkg::beq, 5'd0, 5'd1, 16'd5));
        put(enc_i(mips_pkg::addi, 5'd3, 5'd0, 16'd9));
        put(nop);
        put(nop);
        put(enc_i(mips_pkg::addi, 5'd4, 5'd0, 16'd5));
        // back to the not-taken beq at 12
        put(enc_i(mips_pkg::beq, 5'd0, 5'd0, 16'hfffa));
        end_reset();
        run(8);
    endtask

    task automatic test_jump();
        start_reset();
        put(enc_i(mips_pkg::addi, 5'd1, 5'd0, 16'd1));
        put(enc_j(mips_pkg::jal, 26'd5));
        put(enc_i(mips_pkg::addi, 5'd2, 5'd0, 16'd2));
        put(enc_j(mips_pkg::j, 26'd8));
        put(nop);
        put(enc_i(mips_pkg::addi, 5'd3, 5'd0, 16'd3));
        put(enc_r(mips_pkg::f_jr, 5'd0, 5'd31, 5'd0));
        put(nop);
        put(enc_i(mips_pkg::addi, 5'd4, 5'd0, 16'd4));
        end_reset();
        run(7);
    endtask

    task automatic test_r0();
        start_reset();
        put(enc_i(mips_pkg::addi, 5'd0, 5'd0, 16'd5));
        put(enc_i(mips_pkg::addi, 5'd1, 5'd0, 16'($urandom())));
        put(enc_r(mips_pkg::f_add, 5'd0, 5'd1, 5'd1));
        put(enc_r(mips_pkg::f_add, 5'd2, 5'd0, 5'd1));
        put(enc_r(mips_pkg::f_add, 5'd3, 5'd1, 5'd0));
        end_reset();
        run(5);
    endtask

    initial begin
        void'($urandom(32'h4d40c33c));
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        test_r0();
        $display("%0d error(s) in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- mips_system.f
hdl/mips_pkg.sv
hdl/mips_decoder.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_core.sv
hdl/mips_dmem.sv
hdl/mips_system.sv
dv/mips_system_chk.sv
dv/mips_system_tb.sv

//--- Makefile
# Verilator build and run of the MIPS single-cycle system

VERILATOR ?= verilator
TOP       ?= mips_system_tb
FILELIST  ?= mips_system.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR FLAGS"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
